//--- common/mem_map_pkg.sv
// ----------------------------------------------------------
// memory map definitions
// block size, bank numbers, memory configuration and the
// decode result handed from the map to the bus logic
// ----------------------------------------------------------
`default_nettype none

package mem_map_pkg;

	localparam int BLOCK_AW = 12;	// words per block, log2

	typedef logic [2:0] bank_t;

	localparam bank_t SLOW_BANK = 3'd4;
	localparam bank_t KICK_BANK = 3'd7;	// kickstart image

	// chip_size: 0 one block, 1 two blocks, 2/3 four blocks
	typedef struct packed {
		logic [1:0] chip_size;
		logic       slow_en;
	} mem_cfg_t;

	typedef enum logic [2:0] {
		RGN_CHIP,
		RGN_SLOW,
		RGN_REG,
		RGN_KICK,
		RGN_NONE
	} region_e;

	typedef struct packed {
		region_e               region;
		bank_t                 bank;
		logic [BLOCK_AW-1:0]   offset;
		logic                  wblk;	// write goes nowhere
	} map_t;

endpackage

`default_nettype wire

//--- common/chip_bus_pkg.sv
// ----------------------------------------------------------
// bus transport types
// wishbone classic request/response seen by both masters and
// the physical request that reaches the shared ram
// ----------------------------------------------------------
`default_nettype none

package chip_bus_pkg;

	localparam int DMA_AW = 14;	// dma word address width

	// ----------------------------------------------------------
	// wishbone classic
	// ----------------------------------------------------------
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [1:0]  sel;	// [1] upper byte, [0] lower byte
		logic [15:0] adr;	// word address
		logic [15:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [15:0] dat;
	} wb_rsp_t;

	// ----------------------------------------------------------
	// physical ram side, already mapped to bank/offset
	// ----------------------------------------------------------
	typedef struct packed {
		logic                                stb;	// cyc & stb folded
		logic                                we;
		logic [1:0]                          sel;
		mem_map_pkg::bank_t                  bank;
		logic [mem_map_pkg::BLOCK_AW-1:0]    offset;
		logic [15:0]                         dat;
	} ram_req_t;

endpackage

`default_nettype wire

//--- source/memory/mem_map.sv
// ----------------------------------------------------------
// memory map
// decodes cpu and dma word addresses into region, bank and
// offset, folding chip blocks per the memory configuration
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_map (
	input  wire [15:0]                       cpu_adr_i,
	input  wire                              cpu_we_i,
	input  wire [chip_bus_pkg::DMA_AW-1:0]   dma_adr_i,
	input  wire                              ovl_i,
	input  mem_map_pkg::mem_cfg_t            mem_cfg_i,
	output mem_map_pkg::map_t                cpu_map_o,
	output mem_map_pkg::map_t                dma_map_o
);
	import chip_bus_pkg::*;
	import mem_map_pkg::*;

	logic [15-BLOCK_AW:0] cpu_blk;	// top address nibble

	// chip mirror, block number ANDed with 0, 1 or 3
	function automatic bank_t chip_bank(input logic [1:0] blk, input mem_cfg_t cfg);
		logic [1:0] mask;
		case (cfg.chip_size)
			2'd0:    mask = 2'b00;
			2'd1:    mask = 2'b01;
			default: mask = 2'b11;
		endcase
		return {1'b0, blk & mask};
	endfunction

	assign cpu_blk = cpu_adr_i[15:BLOCK_AW];

	//----------------------------------------------------------
	// cpu side
	//----------------------------------------------------------
	always_comb begin
		cpu_map_o.region = RGN_NONE;
		cpu_map_o.bank   = '0;
		cpu_map_o.offset = cpu_adr_i[BLOCK_AW-1:0];
		cpu_map_o.wblk   = 1'b0;
		case (cpu_blk)
			4'h0, 4'h1, 4'h2, 4'h3: begin
				cpu_map_o.region = RGN_CHIP;
				cpu_map_o.bank   = chip_bank(cpu_blk[1:0], mem_cfg_i);
				if (ovl_i && !cpu_we_i && cpu_blk == 4'h0) begin	// overlay read
					cpu_map_o.region = RGN_KICK;
					cpu_map_o.bank   = KICK_BANK;
				end
			end
			4'h4: if (mem_cfg_i.slow_en) begin
				cpu_map_o.region = RGN_SLOW;
				cpu_map_o.bank   = SLOW_BANK;
			end
			4'hE: cpu_map_o.region = RGN_REG;
			4'hF: begin
				cpu_map_o.region = RGN_KICK;
				cpu_map_o.bank   = KICK_BANK;
				cpu_map_o.wblk   = ~ovl_i;	// rom once boot load is over
			end
			default: ;	// 5..D unmapped
		endcase
	end

	// dma only reaches chip blocks
	assign dma_map_o.region = RGN_CHIP;
	assign dma_map_o.bank   = chip_bank(dma_adr_i[DMA_AW-1:BLOCK_AW], mem_cfg_i);
	assign dma_map_o.offset = dma_adr_i[BLOCK_AW-1:0];
	assign dma_map_o.wblk   = 1'b0;

endmodule

`default_nettype wire

//--- source/memory/chip_arbiter.sv
// ----------------------------------------------------------
// chip ram arbiter
// two masters with dma priority, registered grant held until
// the ram acks, then handed to a waiting master
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module chip_arbiter (
	input  wire                    clk,
	input  wire                    reset,
	input  chip_bus_pkg::ram_req_t dma_req_i,
	input  chip_bus_pkg::ram_req_t cpu_req_i,
	output chip_bus_pkg::ram_req_t ram_req_o,
	input  wire                    ram_ack_i,
	output logic                   dma_ack_o,
	output logic                   cpu_ack_o
);
	import chip_bus_pkg::*;

	logic gnt_dma_q;
	logic gnt_cpu_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			gnt_dma_q <= 1'b0;
			gnt_cpu_q <= 1'b0;
		end else if (ram_ack_i) begin
			// acked master still holds stb this edge, only the other one may go
			gnt_dma_q <= gnt_cpu_q & dma_req_i.stb;
			gnt_cpu_q <= gnt_dma_q & cpu_req_i.stb;
		end else if (!gnt_dma_q && !gnt_cpu_q) begin
			gnt_dma_q <= dma_req_i.stb;	// dma first, like the chipset
			gnt_cpu_q <= ~dma_req_i.stb & cpu_req_i.stb;
		end
	end

	//----------------------------------------------------------
	// request mux and ack return
	//----------------------------------------------------------
	always_comb begin
		ram_req_o = '0;	// idle bus when nobody owns it
		if (gnt_dma_q)
			ram_req_o = dma_req_i;
		else if (gnt_cpu_q)
			ram_req_o = cpu_req_i;
	end

	assign dma_ack_o = ram_ack_i & gnt_dma_q;
	assign cpu_ack_o = ram_ack_i & gnt_cpu_q;

endmodule

`default_nettype wire

//--- source/memory/ram_ctrl.sv
// ----------------------------------------------------------
// shared word ram
// eight banks of 2^BLOCK_AW words, byte lane writes and a
// registered ack with read data one cycle after the strobe
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ram_ctrl (
	input  wire                    clk,
	input  wire                    reset,
	input  chip_bus_pkg::ram_req_t ram_req_i,
	output logic                   ram_ack_o,
	output logic [15:0]            ram_rdata_o
);
	import chip_bus_pkg::*;
	import mem_map_pkg::*;

	localparam int RAM_AW = $bits(bank_t) + BLOCK_AW;

	logic [15:0]       mem [0:(2**RAM_AW)-1];
	logic [RAM_AW-1:0] addr;	// bank:offset
	logic              go;		// first clock of a strobe

	assign addr = {ram_req_i.bank, ram_req_i.offset};
	assign go   = ram_req_i.stb & ~ram_ack_o;	// no repeat while strobe held

	always_ff @(posedge clk) begin
		if (reset)
			ram_ack_o <= 1'b0;
		else
			ram_ack_o <= go;
	end

	//----------------------------------------------------------
	// array access
	//----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (go) begin
			ram_rdata_o <= mem[addr];	// old data on a write cycle
			if (ram_req_i.we && ram_req_i.sel[0])
				mem[addr][7:0] <= ram_req_i.dat[7:0];
			if (ram_req_i.we && ram_req_i.sel[1])
				mem[addr][15:8] <= ram_req_i.dat[15:8];
		end
	end

endmodule

`default_nettype wire

//--- source/sys_regs.sv
// ----------------------------------------------------------
// system registers
// overlay bit and memory configuration with read-back
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sys_regs #(
	parameter mem_map_pkg::mem_cfg_t RESET_MEM_CFG = '{chip_size: 2'd2, slow_en: 1'b1}
) (
	input  wire                   clk,
	input  wire                   reset,
	input  chip_bus_pkg::wb_req_t reg_req_i,
	output logic [15:0]           reg_rdata_o,
	output logic                  reg_ack_o,
	output logic                  ovl_o,
	output mem_map_pkg::mem_cfg_t mem_cfg_o
);
	import chip_bus_pkg::*;
	import mem_map_pkg::*;

	logic                access;	// new register cycle this clock
	logic [BLOCK_AW-1:0] roff;

	assign access = reg_req_i.cyc & reg_req_i.stb & ~reg_ack_o;
	assign roff   = reg_req_i.adr[BLOCK_AW-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_ack_o <= 1'b0;
			ovl_o     <= 1'b1;	// boot with kickstart overlay
			mem_cfg_o <= RESET_MEM_CFG;
		end else begin
			reg_ack_o <= access;
			if (access && reg_req_i.we && reg_req_i.sel[0]) begin	// low lane only
				if (roff == BLOCK_AW'(0))
					ovl_o <= reg_req_i.dat[0];
				if (roff == BLOCK_AW'(1))
					mem_cfg_o <= reg_req_i.dat[2:0];
			end
		end
	end

	always_comb begin
		reg_rdata_o = 16'h0000;	// undefined offsets
		if (roff == BLOCK_AW'(0))
			reg_rdata_o = {15'h0000, ovl_o};
		else if (roff == BLOCK_AW'(1))
			reg_rdata_o = {13'h0000, mem_cfg_o};
	end

endmodule

`default_nettype wire

//--- source/cpu_bridge.sv
// ----------------------------------------------------------
// cpu bridge
// steers each decoded cpu cycle to ram, system registers or
// the local unmapped responder and merges the responses
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_bridge (
	input  wire                    clk,
	input  wire                    reset,
	input  chip_bus_pkg::wb_req_t  cpu_req_i,
	input  mem_map_pkg::map_t      cpu_map_i,
	output chip_bus_pkg::wb_rsp_t  cpu_rsp_o,
	output chip_bus_pkg::ram_req_t ram_req_o,
	input  wire                    ram_ack_i,
	input  wire [15:0]             ram_rdata_i,
	output chip_bus_pkg::wb_req_t  reg_req_o,
	input  wire                    reg_ack_i,
	input  wire [15:0]             reg_rdata_i
);
	import chip_bus_pkg::*;
	import mem_map_pkg::*;

	logic cyc_stb;	// live cpu strobe
	logic is_ram;
	logic is_reg;
	logic is_none;
	logic nm_ack_q;	// unmapped one-shot ack

	assign cyc_stb = cpu_req_i.cyc & cpu_req_i.stb;
	assign is_ram  = (cpu_map_i.region == RGN_CHIP) || (cpu_map_i.region == RGN_SLOW)
		|| (cpu_map_i.region == RGN_KICK);
	assign is_reg  = cpu_map_i.region == RGN_REG;
	assign is_none = cpu_map_i.region == RGN_NONE;

	// ram path, blocked writes still ack but change nothing
	assign ram_req_o.stb    = cyc_stb & is_ram;
	assign ram_req_o.we     = cpu_req_i.we & ~cpu_map_i.wblk;
	assign ram_req_o.sel    = cpu_req_i.sel;
	assign ram_req_o.bank   = cpu_map_i.bank;
	assign ram_req_o.offset = cpu_map_i.offset;
	assign ram_req_o.dat    = cpu_req_i.dat;

	always_comb begin
		reg_req_o     = cpu_req_i;
		reg_req_o.cyc = cpu_req_i.cyc & is_reg;
		reg_req_o.stb = cpu_req_i.stb & is_reg;
	end

	always_ff @(posedge clk) begin
		if (reset)
			nm_ack_q <= 1'b0;
		else
			nm_ack_q <= cyc_stb & is_none & ~nm_ack_q;	// one pulse per cycle
	end

	//----------------------------------------------------------
	// response merge, only one path acks at a time
	//----------------------------------------------------------
	assign cpu_rsp_o.ack = ram_ack_i | reg_ack_i | nm_ack_q;
	assign cpu_rsp_o.dat = ram_ack_i ? ram_rdata_i :
		reg_ack_i ? reg_rdata_i : 16'h0000;	// unmapped reads zero

endmodule

`default_nettype wire

//--- source/chip_bus_top.sv
// ----------------------------------------------------------
// shared memory path top level
// cpu and dma masters share one ram via the arbiter, with the
// cpu side going through the map and the system registers
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module chip_bus_top #(
	parameter mem_map_pkg::mem_cfg_t RESET_MEM_CFG = '{chip_size: 2'd2, slow_en: 1'b1}
) (
	input  wire                   clk,
	input  wire                   reset,
	input  chip_bus_pkg::wb_req_t cpu_req_i,
	output chip_bus_pkg::wb_rsp_t cpu_rsp_o,
	input  chip_bus_pkg::wb_req_t dma_req_i,
	output chip_bus_pkg::wb_rsp_t dma_rsp_o
);
	import chip_bus_pkg::*;
	import mem_map_pkg::*;

	logic        ovl;
	mem_cfg_t    mem_cfg;
	map_t        cpu_map;
	map_t        dma_map;
	ram_req_t    cpu_ram_req;
	ram_req_t    dma_ram_req;
	ram_req_t    arb_ram_req;	// granted request to the ram
	logic        ram_ack;
	logic [15:0] ram_rdata;
	logic        cpu_ram_ack;
	logic        dma_ram_ack;
	wb_req_t     reg_req;
	logic [15:0] reg_rdata;
	logic        reg_ack;

	//----------------------------------------------------------
	// address map for both masters
	//----------------------------------------------------------
	mem_map u_map (
		.cpu_adr_i (cpu_req_i.adr),
		.cpu_we_i  (cpu_req_i.we),
		.dma_adr_i (dma_req_i.adr[DMA_AW-1:0]),	// dma only sees chip space
		.ovl_i     (ovl),
		.mem_cfg_i (mem_cfg),
		.cpu_map_o (cpu_map),
		.dma_map_o (dma_map)
	);

	cpu_bridge u_bridge (
		.clk         (clk),
		.reset       (reset),
		.cpu_req_i   (cpu_req_i),
		.cpu_map_i   (cpu_map),
		.cpu_rsp_o   (cpu_rsp_o),
		.ram_req_o   (cpu_ram_req),
		.ram_ack_i   (cpu_ram_ack),
		.ram_rdata_i (ram_rdata),
		.reg_req_o   (reg_req),
		.reg_ack_i   (reg_ack),
		.reg_rdata_i (reg_rdata)
	);

	sys_regs #(
		.RESET_MEM_CFG (RESET_MEM_CFG)
	) u_regs (
		.clk         (clk),
		.reset       (reset),
		.reg_req_i   (reg_req),
		.reg_rdata_o (reg_rdata),
		.reg_ack_o   (reg_ack),
		.ovl_o       (ovl),
		.mem_cfg_o   (mem_cfg)
	);

	// dma request straight onto the ram side
	assign dma_ram_req.stb    = dma_req_i.cyc & dma_req_i.stb;
	assign dma_ram_req.we     = dma_req_i.we;
	assign dma_ram_req.sel    = dma_req_i.sel;
	assign dma_ram_req.bank   = dma_map.bank;
	assign dma_ram_req.offset = dma_map.offset;
	assign dma_ram_req.dat    = dma_req_i.dat;

	assign dma_rsp_o.ack = dma_ram_ack;
	assign dma_rsp_o.dat = ram_rdata;

	//----------------------------------------------------------
	// arbitration and ram
	//----------------------------------------------------------
	chip_arbiter u_arb (
		.clk       (clk),
		.reset     (reset),
		.dma_req_i (dma_ram_req),
		.cpu_req_i (cpu_ram_req),
		.ram_req_o (arb_ram_req),
		.ram_ack_i (ram_ack),
		.dma_ack_o (dma_ram_ack),
		.cpu_ack_o (cpu_ram_ack)
	);

	ram_ctrl u_ram (
		.clk         (clk),
		.reset       (reset),
		.ram_req_i   (arb_ram_req),
		.ram_ack_o   (ram_ack),
		.ram_rdata_o (ram_rdata)
	);

endmodule

`default_nettype wire

//--- verification/chip_bus_checker.sv
// ----------------------------------------------------------
// arbiter checker
// grant exclusivity, ack ownership and kickstart protection
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module chip_bus_checker (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    gnt_dma_i,
	input  wire                    gnt_cpu_i,
	input  wire                    ram_ack_i,
	input  wire                    dma_ack_i,
	input  wire                    cpu_ack_i,
	input  wire                    ovl_i,
	input  chip_bus_pkg::ram_req_t ram_req_i,
	input  chip_bus_pkg::ram_req_t dma_req_i,
	input  chip_bus_pkg::ram_req_t cpu_req_i
);
	import chip_bus_pkg::*;
	import mem_map_pkg::*;

	one_grant: assert property (@(posedge clk) disable iff (reset)
		!(gnt_dma_i && gnt_cpu_i)) else $error("dma and cpu granted together");

	ack_with_stb: assert property (@(posedge clk) disable iff (reset)
		ram_ack_i |-> ram_req_i.stb) else $error("ram ack without strobe");

	dma_ack_owner: assert property (@(posedge clk) disable iff (reset)
		dma_ack_i |-> dma_req_i.stb) else $error("dma ack without dma strobe");

	cpu_ack_owner: assert property (@(posedge clk) disable iff (reset)
		cpu_ack_i |-> cpu_req_i.stb) else $error("cpu ack without cpu strobe");

	// kickstart is rom once the overlay is gone
	no_kick_write: assert property (@(posedge clk) disable iff (reset)
		(ram_req_i.stb && ram_req_i.we && !ovl_i) |-> ram_req_i.bank != KICK_BANK)
		else $error("kickstart bank written with overlay clear");

endmodule

`default_nettype wire

//--- verification/tb_chip_bus.sv
// ----------------------------------------------------------
// shared memory path testbench
// lfsr driven cpu and dma traffic checked against a word model
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_chip_bus;
	import chip_bus_pkg::*;
	import mem_map_pkg::*;

	localparam mem_cfg_t TB_CFG = '{chip_size: 2'd1, slow_en: 1'b0};	// two chip blocks
	localparam int N_PRE = 97;	// cfg write plus six banks of 16 words
	localparam int N_OVL = 32;
	localparam int N_ROM = 16;
	localparam int N_CFG = 8;
	localparam int N_MIX = 64;
	localparam int TOTAL_OPS = 2 + N_PRE + 3 * N_OVL + 17 + 2 * N_ROM + 9 * N_CFG + 2 * N_MIX;
	localparam int TIMEOUT_CYC = TOTAL_OPS * 8;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	wb_req_t     cpu_req;
	wb_req_t     dma_req;
	wb_rsp_t     cpu_rsp;
	wb_rsp_t     dma_rsp;
	logic [31:0] lfsr = 32'h4cbd_5c55;
	logic [15:0] model_mem [0:8*4096-1];	// bank:offset
	logic        m_ovl = 1'b1;
	logic [2:0]  m_cfg = TB_CFG;	// {chip_size, slow_en}
	int          checks = 0;
	int          errors = 0;
	int          test_err0 = 0;
	int          cycles = 0;

	always #4 clk = ~clk;

	chip_bus_top #(
		.RESET_MEM_CFG (TB_CFG)
	) dut0 (
		.clk       (clk),
		.reset     (reset),
		.cpu_req_i (cpu_req),
		.cpu_rsp_o (cpu_rsp),
		.dma_req_i (dma_req),
		.dma_rsp_o (dma_rsp)
	);

	bind chip_bus_top chip_bus_checker chk0 (
		.clk       (clk),
		.reset     (reset),
		.gnt_dma_i (u_arb.gnt_dma_q),
		.gnt_cpu_i (u_arb.gnt_cpu_q),
		.ram_ack_i (ram_ack),
		.dma_ack_i (dma_ram_ack),
		.cpu_ack_i (cpu_ram_ack),
		.ovl_i     (ovl),
		.ram_req_i (arb_ram_req),
		.dma_req_i (dma_ram_req),
		.cpu_req_i (cpu_ram_req)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("timeout after %0d cycles, a request was never acknowledged", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//----------------------------------------------------------
	// random source and reference model
	//----------------------------------------------------------
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];	// taps 32,22,2,1
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	// chip block mirror per chip_size
	function automatic int fold_bank(input logic [1:0] blk);
		case (m_cfg[2:1])
			2'd0:    return 0;
			2'd1:    return int'(blk[0]);
			default: return int'(blk);
		endcase
	endfunction

	// word index or -1 for registers and -2 for unmapped
	function automatic int cpu_index(input logic [15:0] adr, input logic we);
		logic [3:0] blk;
		blk = adr[15:12];
		if (blk <= 4'h3) begin
			if (m_ovl && !we && blk == 4'h0)
				return 7 * 4096 + int'(adr[11:0]);	// overlay read
			return fold_bank(blk[1:0]) * 4096 + int'(adr[11:0]);
		end
		if (blk == 4'h4)
			return m_cfg[0] ? 4 * 4096 + int'(adr[11:0]) : -2;
		if (blk == 4'hE)
			return -1;
		if (blk == 4'hF)
			return 7 * 4096 + int'(adr[11:0]);
		return -2;
	endfunction

	task automatic model_write(input int idx, input logic [1:0] sel, input logic [15:0] dat);
		if (sel[0])
			model_mem[idx][7:0] = dat[7:0];
		if (sel[1])
			model_mem[idx][15:8] = dat[15:8];
	endtask

	task automatic check_value(input string name, input logic [15:0] exp,
		input logic [15:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	//----------------------------------------------------------
	// bus masters with the model applied at ack
	//----------------------------------------------------------
	task automatic cpu_access(input logic we, input logic [1:0] sel, input logic [15:0] adr,
		input logic [15:0] dat);
		int          idx;
		logic [15:0] exp;
		@(posedge clk);
		cpu_req <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
		@(negedge clk);
		while (!cpu_rsp.ack)
			@(negedge clk);
		idx = cpu_index(adr, we);
		exp = 16'h0000;
		if (idx == -1) begin
			if (adr[11:0] == 12'd0)
				exp = {15'h0000, m_ovl};
			else if (adr[11:0] == 12'd1)
				exp = {13'h0000, m_cfg};
			if (we && sel[0] && adr[11:0] == 12'd0)
				m_ovl = dat[0];
			if (we && sel[0] && adr[11:0] == 12'd1)
				m_cfg = dat[2:0];
		end else if (idx >= 0) begin
			exp = model_mem[idx];
			if (we && !(adr[15:12] == 4'hF && !m_ovl))	// rom after boot
				model_write(idx, sel, dat);
		end
		if (!we)
			check_value("cpu_rsp_o.dat", exp, cpu_rsp.dat);
		@(posedge clk);
		cpu_req <= '0;
	endtask

	task automatic dma_access(input logic we, input logic [1:0] sel, input logic [13:0] adr,
		input logic [15:0] dat);
		int idx;
		@(posedge clk);
		dma_req <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: {2'b00, adr}, dat: dat};
		@(negedge clk);
		while (!dma_rsp.ack)
			@(negedge clk);
		idx = fold_bank(adr[13:12]) * 4096 + int'(adr[11:0]);
		if (!we)
			check_value("dma_rsp_o.dat", model_mem[idx], dma_rsp.dat);
		else
			model_write(idx, sel, dat);
		@(posedge clk);
		dma_req <= '0;
	endtask

	task automatic test_done(input string name);
		$display("test %s: %s, %0d errors", name, (errors == test_err0) ? "ok" : "failed",
			errors - test_err0);
		test_err0 = errors;
	endtask

	initial begin : main
		logic [3:0]  blk;
		logic [3:0]  off;
		logic        c_we;
		logic [1:0]  c_sel;
		logic [15:0] c_dat;
		logic        d_we;
		logic [1:0]  d_sel;
		logic [13:0] d_adr;
		logic [15:0] d_dat;
		cpu_req = '0;
		dma_req = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		cpu_access(1'b0, 2'b11, 16'hE000, 16'h0000);
		cpu_access(1'b0, 2'b11, 16'hE001, 16'h0000);
		test_done("reset values");

		// four chip blocks plus slow ram so every bank gets filled
		cpu_access(1'b1, 2'b01, 16'hE001, 16'h0005);
		for (int b = 0; b < 5; b++)
			for (int o = 0; o < 16; o++)
				cpu_access(1'b1, 2'b11, 16'(b * 4096 + o), 16'(rand_bits(16)));
		for (int o = 0; o < 16; o++)
			cpu_access(1'b1, 2'b11, 16'(16'hF000 + o), 16'(rand_bits(16)));
		for (int i = 0; i < N_OVL; i++) begin
			off = 4'(rand_bits(4));
			cpu_access(1'b1, 2'b11, {12'hF00, off}, 16'(rand_bits(16)));
			cpu_access(1'b0, 2'b11, {12'hF00, off}, 16'h0000);
			cpu_access(1'b0, 2'b11, {12'h000, off}, 16'h0000);
		end
		cpu_access(1'b1, 2'b01, 16'hE000, 16'h0000);	// overlay off
		for (int o = 0; o < 16; o++)
			cpu_access(1'b0, 2'b11, 16'(o), 16'h0000);
		test_done("overlay boot load");

		for (int i = 0; i < N_ROM; i++) begin
			c_sel = 2'(rand_bits(2));
			off   = 4'(rand_bits(4));
			c_dat = 16'(rand_bits(16));
			cpu_access(1'b1, c_sel, {12'hF00, off}, c_dat);
		end
		for (int o = 0; o < 16; o++)
			cpu_access(1'b0, 2'b11, 16'(16'hF000 + o), 16'h0000);
		test_done("kickstart protect");

		for (int i = 0; i < N_CFG; i++) begin
			cpu_access(1'b1, 2'b01, 16'hE001, {13'h0000, 3'(rand_bits(3))});
			for (int j = 0; j < 8; j++) begin
				blk   = 4'(rand_bits(4) % 14);	// blocks 0..D without registers
				c_we  = 1'(rand_bits(1));
				c_sel = 2'(rand_bits(2));
				off   = 4'(rand_bits(4));
				c_dat = 16'(rand_bits(16));
				cpu_access(c_we, c_sel, {blk, 8'h00, off}, c_dat);
			end
		end
		test_done("memory config");

		for (int i = 0; i < N_MIX; i++) begin
			blk = 4'(rand_bits(4));
			if (blk == 4'hE)
				blk = 4'hF;
			off   = 4'(rand_bits(4));
			c_we  = 1'(rand_bits(1));
			c_sel = 2'(rand_bits(2));
			c_dat = 16'(rand_bits(16));
			d_we  = 1'(rand_bits(1));
			d_sel = 2'(rand_bits(2));
			d_adr = {2'(rand_bits(2)), 8'h00, 4'(rand_bits(4))};
			d_dat = 16'(rand_bits(16));
			fork
				cpu_access(c_we, c_sel, {blk, 8'h00, off}, c_dat);
				dma_access(d_we, d_sel, d_adr, d_dat);
			join
		end
		test_done("cpu and dma traffic");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
common/mem_map_pkg.sv
common/chip_bus_pkg.sv
source/memory/mem_map.sv
source/memory/chip_arbiter.sv
source/memory/ram_ctrl.sv
source/sys_regs.sv
source/cpu_bridge.sv
source/chip_bus_top.sv
verification/chip_bus_checker.sv
verification/tb_chip_bus.sv

//--- run.sh
#!/bin/sh
# build and run the shared memory path testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_chip_bus -o sim_chip_bus
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_chip_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: PASS" sim.log; then
	exit 0
fi
exit 1
